// ==== verilog.f ====
src/flop_ram_pkg.sv
src/flop_ram_write.sv
src/flop_ram_array.sv
src/flop_ram_read.sv
src/ram_watch_checker.sv
src/flop_ram_top.sv
tb/tb_clkgen.sv
tb/flop_ram_tb.sv

// ==== Makefile ====
TOP := flop_ram_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== tb/flop_ram_tb.sv ====
// Flop RAM testbench, table-driven traffic checked against a reference memory model
`timescale 1ns/10ps

module flop_ram_tb;

  import flop_ram_pkg::*;

  localparam int drain_limit = 10;
  localparam int rst_limit   = 20;

  typedef struct packed {
    logic [7:0]    test_id;
    wr_req_t [1:0] wr;
    rd_req_t [1:0] rd;
  } step_t;

  typedef struct packed {
    int                due;
    logic [data_w-1:0] data;
  } expect_t;

  logic                wr_clk;
  logic                wr_rst;
  wr_req_t [1:0]       wr_req;
  rd_req_t [1:0]       rd_req;
  logic [addr_w-1:0]   watch_addr;
  logic                watch_port;
  rd_resp_t [1:0]      rd_resp;
  logic                check_err;
  logic [cnt_w-1:0]    check_err_count;

  step_t             steps[$];
  expect_t           exp_q0[$];
  expect_t           exp_q1[$];
  logic [data_w-1:0] ref_mem [ram_depth];
  int                cycle;
  int                test_checks;
  int                test_errs;
  int                total_checks;
  int                total_errs;
  int                tests_run;

  tb_clkgen u_clkgen (
    .wr_clk (wr_clk),
    .wr_rst (wr_rst)
  );

  flop_ram_top #(
    .num_wr_ports  (2),
    .num_rd_ports  (2),
    .wr_latency    (1),
    .rd_latency    (1),
    .enable_bypass (1),
    .enable_reset  (1)
  ) dut0 (
    .wr_clk          (wr_clk),
    .wr_rst          (wr_rst),
    .wr_req          (wr_req),
    .rd_req          (rd_req),
    .watch_addr      (watch_addr),
    .watch_port      (watch_port),
    .rd_resp         (rd_resp),
    .check_err       (check_err),
    .check_err_count (check_err_count)
  );

  function automatic wr_req_t write_req(input logic v, input logic [addr_w-1:0] a,
                                        input logic [data_w-1:0] d,
                                        input logic [num_lanes-1:0] lanes);
    wr_req_t w;
    w.valid   = v;
    w.addr    = a;
    w.data    = d;
    w.lane_en = lanes;
    return w;
  endfunction

  function automatic rd_req_t read_req(input logic v, input logic [addr_w-1:0] a);
    rd_req_t r;
    r.valid = v;
    r.addr  = a;
    return r;
  endfunction

  // Enabled lanes of a write replace the old word
  function automatic logic [data_w-1:0] merge_lanes(input logic [data_w-1:0] old_word,
                                                    input wr_req_t w);
    logic [data_w-1:0] word;
    word = old_word;
    for (int l = 0; l < num_lanes; l++) begin
      if (w.lane_en[l]) word[l*lane_w +: lane_w] = w.data[l*lane_w +: lane_w];
    end
    return word;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1: return "reset contents read as zero";
      2: return "full-word writes and read latency";
      3: return "partial lane writes";
      4: return "same-cycle write to read bypass";
      5: return "write port collision";
      6: return "watch monitor on random traffic";
      default: return "idle";
    endcase
  endfunction

  function automatic int pending(input int r);
    return (r == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  task automatic queue_step(input int id, input wr_req_t w0, input wr_req_t w1,
                            input rd_req_t r0, input rd_req_t r1);
    step_t s;
    s.test_id = 8'(id);
    s.wr[0]   = w0;
    s.wr[1]   = w1;
    s.rd[0]   = r0;
    s.rd[1]   = r1;
    steps.push_back(s);
  endtask

  task automatic check_responses();
    expect_t e;
    for (int r = 0; r < 2; r++) begin
      if (rd_resp[r].valid) begin
        if (pending(r) == 0) begin
          $display("Read port %0d returned a response that no read asked for at %0t", r, $time);
          test_errs++;
        end else begin
          if (r == 0) e = exp_q0.pop_front();
          else e = exp_q1.pop_front();
          test_checks++;
          if (e.due != cycle) begin
            $display("MISMATCH at %0t: read port %0d response in cycle %0d, expected cycle %0d",
                     $time, r, cycle, e.due);
            test_errs++;
          end
          if (rd_resp[r].data != e.data) begin
            $display("MISMATCH at %0t: read port %0d data %h, expected %h",
                     $time, r, rd_resp[r].data, e.data);
            test_errs++;
          end
        end
      end
    end
    if (check_err) begin
      $display("MISMATCH at %0t: check_err pulsed on correct read data", $time);
      test_errs++;
    end
  endtask

  task automatic apply_step(input step_t s);
    wr_req_t [1:0]     w;
    logic [data_w-1:0] word;
    expect_t           e;
    w = s.wr;
    // Port 1 takes the whole write when both ports hit one address
    if (w[0].valid && w[1].valid && (w[0].addr == w[1].addr)) w[0].valid = 1'b0;
    @(posedge wr_clk);
    #1;
    wr_req = s.wr;
    rd_req = s.rd;
    cycle++;
    for (int r = 0; r < 2; r++) begin
      if (s.rd[r].valid) begin
        word = ref_mem[s.rd[r].addr];
        for (int p = 0; p < 2; p++) begin
          if (w[p].valid && (w[p].addr == s.rd[r].addr)) word = merge_lanes(word, w[p]);
        end
        e.due  = cycle + 2;
        e.data = word;
        if (r == 0) exp_q0.push_back(e);
        else exp_q1.push_back(e);
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (w[p].valid) ref_mem[w[p].addr] = merge_lanes(ref_mem[w[p].addr], w[p]);
    end
    @(negedge wr_clk);
    check_responses();
  endtask

  task automatic drain_pending(input int id);
    step_t idle;
    int    waited;
    idle         = '0;
    idle.test_id = 8'(id);
    waited       = 0;
    while ((pending(0) != 0 || pending(1) != 0) && waited < drain_limit) begin
      apply_step(idle);
      waited++;
    end
    for (int r = 0; r < 2; r++) begin
      if (pending(r) != 0) begin
        $display("Timeout: %0d response(s) on read port %0d never arrived in test %0d",
                 pending(r), r, id);
        test_errs++;
      end
    end
    exp_q0.delete();
    exp_q1.delete();
  endtask

  task automatic finish_test(input int id);
    if (id == 6 && check_err_count != '0) begin
      $display("MISMATCH at %0t: check_err_count is %0d, expected 0", $time, check_err_count);
      test_errs++;
    end
    $display("Test %0d (%s): %0d checks, %0d errors, %s", id, test_name(id), test_checks,
             test_errs, (test_errs == 0) ? "ok" : "failed");
    total_checks += test_checks;
    total_errs   += test_errs;
    tests_run++;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic build_table();
    wr_req_t no_wr;
    rd_req_t no_rd;
    no_wr = '0;
    no_rd = '0;
    for (int i = 0; i < 8; i++) begin
      queue_step(1, no_wr, no_wr, read_req(1, addr_w'(i)), read_req(1, addr_w'(i + 8)));
    end
    for (int i = 0; i < 4; i++) begin
      queue_step(2, write_req(1, addr_w'(i), $urandom, 4'hf),
                 write_req(1, addr_w'(i + 8), $urandom, 4'hf), no_rd, no_rd);
    end
    // Cross the ports so each read port sees the other write port's data
    for (int i = 0; i < 4; i++) begin
      queue_step(2, no_wr, no_wr, read_req(1, addr_w'(i + 8)), read_req(1, addr_w'(i)));
    end
    queue_step(3, write_req(1, 1, $urandom, 4'b0011), write_req(1, 2, $urandom, 4'b1000),
               no_rd, no_rd);
    queue_step(3, write_req(1, 1, $urandom, 4'b0100), write_req(1, 9, $urandom, 4'b0110),
               no_rd, no_rd);
    queue_step(3, no_wr, no_wr, read_req(1, 1), read_req(1, 2));
    queue_step(3, no_wr, no_wr, read_req(1, 9), read_req(1, 3));
    queue_step(4, write_req(1, 5, $urandom, 4'hf), no_wr, no_rd, no_rd);
    queue_step(4, write_req(1, 5, $urandom, 4'b0101), no_wr, read_req(1, 5), read_req(1, 5));
    queue_step(4, no_wr, write_req(1, 5, $urandom, 4'b1000), read_req(1, 5), no_rd);
    queue_step(4, no_wr, no_wr, read_req(1, 5), no_rd);
    queue_step(5, write_req(1, 6, $urandom, 4'hf), no_wr, no_rd, no_rd);
    queue_step(5, write_req(1, 6, $urandom, 4'hf), write_req(1, 6, $urandom, 4'b0011),
               read_req(1, 6), no_rd);
    queue_step(5, no_wr, no_wr, read_req(1, 6), read_req(1, 6));
    // Addresses 4 to 6 keep the watched entry busy
    for (int i = 0; i < 48; i++) begin
      queue_step(6,
                 write_req(1'($urandom), addr_w'(4 + $urandom % 3), $urandom, 4'($urandom)),
                 write_req(1'($urandom), addr_w'(4 + $urandom % 3), $urandom, 4'($urandom)),
                 read_req(1'($urandom), addr_w'(4 + $urandom % 3)),
                 read_req(1'($urandom), addr_w'(4 + $urandom % 3)));
    end
  endtask

  initial begin
    int seed_val;
    int waited;
    wr_req       = '0;
    rd_req       = '0;
    watch_addr   = 4'd5;
    watch_port   = 1'b1;
    cycle        = 0;
    test_checks  = 0;
    test_errs    = 0;
    total_checks = 0;
    total_errs   = 0;
    tests_run    = 0;
    seed_val     = $urandom(32'h57fff575);
    for (int e = 0; e < ram_depth; e++) ref_mem[e] = '0;
    build_table();

    // Look at reset only after the first falling edge
    waited = 0;
    do begin
      @(negedge wr_clk);
      waited++;
    end while (wr_rst && waited < rst_limit);
    if (wr_rst) begin
      $display("Timeout: reset was never released");
      total_errs++;
    end else begin
      for (int i = 0; i < steps.size(); i++) begin
        apply_step(steps[i]);
        if (i == steps.size() - 1 || steps[i+1].test_id != steps[i].test_id) begin
          drain_pending(steps[i].test_id);
          finish_test(steps[i].test_id);
        end
      end
    end

    $display("Tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clkgen.sv ====
// Testbench clock and reset generator, 8 ns clock with reset held for the first cycles
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int rst_cycles = 4
) (
  output logic wr_clk,
  output logic wr_rst
);

  initial begin
    wr_clk = 1'b0;
    forever #4 wr_clk = ~wr_clk;
  end

  initial begin
    wr_rst = 1'b1;
    repeat (rst_cycles) @(posedge wr_clk);
    wr_rst <= 1'b0;
  end

endmodule

// ==== src/flop_ram_top.sv ====
// Flop RAM top level with write stage, storage, read stage and watch monitor
`timescale 1ns/10ps

module flop_ram_top #(
  parameter int  num_wr_ports  = 2,
  parameter int  num_rd_ports  = 2,
  parameter int  wr_latency    = 1,
  parameter int  rd_latency    = 1,
  parameter bit  enable_bypass = 1,
  parameter bit  enable_reset  = 1,
  localparam int port_w        = (num_rd_ports > 1) ? $clog2(num_rd_ports) : 1
) (
  input  logic                                       wr_clk,
  input  logic                                       wr_rst,
  input  flop_ram_pkg::wr_req_t [num_wr_ports-1:0]   wr_req,
  input  flop_ram_pkg::rd_req_t [num_rd_ports-1:0]   rd_req,
  input  logic [flop_ram_pkg::addr_w-1:0]            watch_addr,
  input  logic [port_w-1:0]                          watch_port,
  output flop_ram_pkg::rd_resp_t [num_rd_ports-1:0]  rd_resp,
  output logic                                       check_err,
  output logic [flop_ram_pkg::cnt_w-1:0]             check_err_count
);

  import flop_ram_pkg::*;

  wr_req_t [num_wr_ports-1:0]             mem_wr;
  rd_req_t [num_rd_ports-1:0]             arr_rd;
  logic [num_rd_ports-1:0][data_w-1:0]    arr_data;

  flop_ram_write #(
    .num_wr_ports (num_wr_ports),
    .wr_latency   (wr_latency)
  ) u_write (
    .wr_clk (wr_clk),
    .wr_rst (wr_rst),
    .wr_req (wr_req),
    .mem_wr (mem_wr)
  );

  flop_ram_array #(
    .num_wr_ports  (num_wr_ports),
    .num_rd_ports  (num_rd_ports),
    .enable_bypass (enable_bypass),
    .enable_reset  (enable_reset)
  ) u_array (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .mem_wr   (mem_wr),
    .arr_rd   (arr_rd),
    .arr_data (arr_data)
  );

  flop_ram_read #(
    .num_rd_ports (num_rd_ports),
    .wr_latency   (wr_latency),
    .rd_latency   (rd_latency)
  ) u_read (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .rd_req   (rd_req),
    .arr_rd   (arr_rd),
    .arr_data (arr_data),
    .rd_resp  (rd_resp)
  );

  ram_watch_checker #(
    .num_wr_ports  (num_wr_ports),
    .num_rd_ports  (num_rd_ports),
    .wr_latency    (wr_latency),
    .rd_latency    (rd_latency),
    .enable_bypass (enable_bypass),
    .enable_reset  (enable_reset)
  ) u_watch (
    .wr_clk          (wr_clk),
    .wr_rst          (wr_rst),
    .wr_req          (wr_req),
    .rd_req          (rd_req),
    .rd_resp         (rd_resp),
    .watch_addr      (watch_addr),
    .watch_port      (watch_port),
    .check_err       (check_err),
    .check_err_count (check_err_count)
  );

endmodule

// ==== src/ram_watch_checker.sv ====
// RAM watch monitor, shadows one address and counts read data mismatches on one read port
`timescale 1ns/10ps

module ram_watch_checker #(
  parameter int  num_wr_ports  = 2,
  parameter int  num_rd_ports  = 2,
  parameter int  wr_latency    = 1,
  parameter int  rd_latency    = 1,
  parameter bit  enable_bypass = 1,
  parameter bit  enable_reset  = 1,
  localparam int port_w        = (num_rd_ports > 1) ? $clog2(num_rd_ports) : 1
) (
  input  logic                                       wr_clk,
  input  logic                                       wr_rst,
  input  flop_ram_pkg::wr_req_t [num_wr_ports-1:0]   wr_req,
  input  flop_ram_pkg::rd_req_t [num_rd_ports-1:0]   rd_req,
  input  flop_ram_pkg::rd_resp_t [num_rd_ports-1:0]  rd_resp,
  input  logic [flop_ram_pkg::addr_w-1:0]            watch_addr,
  input  logic [port_w-1:0]                          watch_port,
  output logic                                       check_err,
  output logic [flop_ram_pkg::cnt_w-1:0]             check_err_count
);

  import flop_ram_pkg::*;

  localparam int total_lat = wr_latency + rd_latency;

  typedef struct packed {
    logic                              valid;
    logic [num_lanes-1:0]              mask;
    logic [num_lanes-1:0][lane_w-1:0]  expect_word;
  } chk_t;

  logic [num_lanes-1:0][lane_w-1:0] shadow;
  logic [num_lanes-1:0][lane_w-1:0] shadow_nxt;
  logic [num_lanes-1:0][lane_w-1:0] hit_data;
  logic [num_lanes-1:0]             hit_en;
  logic [num_lanes-1:0]             written;
  logic [num_lanes-1:0]             lane_diff;
  logic                             hit_wr;
  chk_t                             chk_in;
  chk_t                             chk_out;
  rd_resp_t                         resp;

  // Highest-index port hitting the watched address wins
  always_comb begin
    hit_wr   = 1'b0;
    hit_data = '0;
    hit_en   = '0;
    for (int p = 0; p < num_wr_ports; p++) begin
      if (wr_req[p].valid && (wr_req[p].addr == watch_addr)) begin
        hit_wr   = 1'b1;
        hit_data = wr_req[p].data;
        hit_en   = wr_req[p].lane_en;
      end
    end
    for (int l = 0; l < num_lanes; l++) begin
      shadow_nxt[l] = (hit_wr && hit_en[l]) ? hit_data[l] : shadow[l];
    end
  end

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      shadow  <= '0;
      written <= '0;
    end else if (hit_wr) begin
      shadow  <= shadow_nxt;
      written <= written | hit_en;
    end
  end

  // Expected word and checked lanes at read issue time
  always_comb begin
    chk_in.valid = rd_req[watch_port].valid && (rd_req[watch_port].addr == watch_addr);
    chk_in.mask  = enable_reset ? {num_lanes{1'b1}} : written;
    if (enable_bypass) begin
      chk_in.expect_word = shadow_nxt;
      if (hit_wr) chk_in.mask = chk_in.mask | hit_en;
    end else begin
      chk_in.expect_word = shadow;
    end
  end

  if (total_lat == 0) begin : gen_chk_direct
    assign chk_out = chk_in;
  end else begin : gen_chk_delay
    chk_t chk_pipe [total_lat];

    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        for (int k = 0; k < total_lat; k++) chk_pipe[k] <= '0;
      end else begin
        chk_pipe[0] <= chk_in;
        for (int k = 1; k < total_lat; k++) chk_pipe[k] <= chk_pipe[k-1];
      end
    end

    assign chk_out = chk_pipe[total_lat-1];
  end

  assign resp = rd_resp[watch_port];

  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      lane_diff[l] = chk_out.mask[l] &&
                     (resp.data[l*lane_w +: lane_w] != chk_out.expect_word[l]);
    end
  end

  // A missing response counts as an error too
  assign check_err = chk_out.valid && (!resp.valid || (|lane_diff));

  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      check_err_count <= '0;
    end else if (check_err && (check_err_count != {cnt_w{1'b1}})) begin
      check_err_count <= check_err_count + 1'b1;
    end
  end

endmodule

// ==== src/flop_ram_read.sv ====
// Flop RAM read stage, aligns reads behind writes and retimes read data by the read latency
`timescale 1ns/10ps

module flop_ram_read #(
  parameter int num_rd_ports = 2,
  parameter int wr_latency   = 1,
  parameter int rd_latency   = 1
) (
  input  logic                                               wr_clk,
  input  logic                                               wr_rst,
  input  flop_ram_pkg::rd_req_t [num_rd_ports-1:0]           rd_req,
  output flop_ram_pkg::rd_req_t [num_rd_ports-1:0]           arr_rd,
  input  logic [num_rd_ports-1:0][flop_ram_pkg::data_w-1:0]  arr_data,
  output flop_ram_pkg::rd_resp_t [num_rd_ports-1:0]          rd_resp
);

  import flop_ram_pkg::*;

  rd_resp_t [num_rd_ports-1:0] resp_in;

  // Match the write path delay so same-cycle writes land first
  if (wr_latency == 0) begin : gen_req_direct
    assign arr_rd = rd_req;
  end else begin : gen_req_delay
    rd_req_t [num_rd_ports-1:0] req_pipe [wr_latency];

    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        for (int k = 0; k < wr_latency; k++) req_pipe[k] <= '0;
      end else begin
        req_pipe[0] <= rd_req;
        for (int k = 1; k < wr_latency; k++) req_pipe[k] <= req_pipe[k-1];
      end
    end

    assign arr_rd = req_pipe[wr_latency-1];
  end

  always_comb begin
    for (int r = 0; r < num_rd_ports; r++) begin
      resp_in[r].valid = arr_rd[r].valid;
      resp_in[r].data  = arr_data[r];
    end
  end

  // Read data pipeline; every stage may hold a response in flight
  if (rd_latency == 0) begin : gen_resp_direct
    assign rd_resp = resp_in;
  end else begin : gen_resp_delay
    rd_resp_t [num_rd_ports-1:0] resp_pipe [rd_latency];

    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        for (int k = 0; k < rd_latency; k++) resp_pipe[k] <= '0;
      end else begin
        resp_pipe[0] <= resp_in;
        for (int k = 1; k < rd_latency; k++) resp_pipe[k] <= resp_pipe[k-1];
      end
    end

    assign rd_resp = resp_pipe[rd_latency-1];
  end

endmodule

// ==== src/flop_ram_array.sv ====
// Flop RAM storage array with per-lane writes and combinational reads with optional bypass
`timescale 1ns/10ps

module flop_ram_array #(
  parameter int num_wr_ports  = 2,
  parameter int num_rd_ports  = 2,
  parameter bit enable_bypass = 1,
  parameter bit enable_reset  = 1
) (
  input  logic                                                wr_clk,
  input  logic                                                wr_rst,
  input  flop_ram_pkg::wr_req_t [num_wr_ports-1:0]            mem_wr,
  input  flop_ram_pkg::rd_req_t [num_rd_ports-1:0]            arr_rd,
  output logic [num_rd_ports-1:0][flop_ram_pkg::data_w-1:0]   arr_data
);

  import flop_ram_pkg::*;

  typedef logic [num_lanes-1:0][lane_w-1:0] word_t;

  word_t                mem [ram_depth];
  logic [num_lanes-1:0] lane_we [ram_depth];
  word_t                lane_wd [ram_depth];

  // Per-entry lane enables and data; later ports take precedence
  always_comb begin
    for (int e = 0; e < ram_depth; e++) begin
      lane_we[e] = '0;
      lane_wd[e] = mem[e];
      for (int p = 0; p < num_wr_ports; p++) begin
        if (mem_wr[p].valid && (mem_wr[p].addr == addr_w'(e))) begin
          for (int l = 0; l < num_lanes; l++) begin
            if (mem_wr[p].lane_en[l]) begin
              lane_we[e][l] = 1'b1;
              lane_wd[e][l] = mem_wr[p].data[l*lane_w +: lane_w];
            end
          end
        end
      end
    end
  end

  if (enable_reset) begin : gen_mem_rst
    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        for (int e = 0; e < ram_depth; e++) begin
          mem[e] <= '0;
        end
      end else begin
        for (int e = 0; e < ram_depth; e++) begin
          for (int l = 0; l < num_lanes; l++) begin
            if (lane_we[e][l]) mem[e][l] <= lane_wd[e][l];
          end
        end
      end
    end
  end else begin : gen_mem_nrst
    always_ff @(posedge wr_clk) begin
      for (int e = 0; e < ram_depth; e++) begin
        for (int l = 0; l < num_lanes; l++) begin
          if (lane_we[e][l]) mem[e][l] <= lane_wd[e][l];
        end
      end
    end
  end

  // Read mux, with same-cycle write lanes forwarded when bypass is on
  always_comb begin
    word_t rd_word;
    for (int r = 0; r < num_rd_ports; r++) begin
      rd_word = mem[arr_rd[r].addr];
      if (enable_bypass) begin
        for (int p = 0; p < num_wr_ports; p++) begin
          if (mem_wr[p].valid && (mem_wr[p].addr == arr_rd[r].addr)) begin
            for (int l = 0; l < num_lanes; l++) begin
              if (mem_wr[p].lane_en[l]) rd_word[l] = mem_wr[p].data[l*lane_w +: lane_w];
            end
          end
        end
      end
      arr_data[r] = rd_word;
    end
  end

endmodule

// ==== src/flop_ram_write.sv ====
// Flop RAM write stage, resolves same-address port collisions and applies write latency
`timescale 1ns/10ps

module flop_ram_write #(
  parameter int num_wr_ports = 2,
  parameter int wr_latency   = 1
) (
  input  logic                                         wr_clk,
  input  logic                                         wr_rst,
  input  flop_ram_pkg::wr_req_t [num_wr_ports-1:0]     wr_req,
  output flop_ram_pkg::wr_req_t [num_wr_ports-1:0]     mem_wr
);

  import flop_ram_pkg::*;

  wr_req_t [num_wr_ports-1:0] resolved;

  // A higher-index port hitting the same address wins,
  // so the losing lower port is simply dropped
  always_comb begin
    resolved = wr_req;
    for (int i = 0; i < num_wr_ports; i++) begin
      for (int j = i + 1; j < num_wr_ports; j++) begin
        if (wr_req[i].valid && wr_req[j].valid && (wr_req[j].addr == wr_req[i].addr)) begin
          resolved[i].valid = 1'b0;
        end
      end
    end
  end

  if (wr_latency == 0) begin : gen_no_delay
    assign mem_wr = resolved;
  end else begin : gen_delay
    wr_req_t [num_wr_ports-1:0] stage [wr_latency];

    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        for (int k = 0; k < wr_latency; k++) begin
          stage[k] <= '0;
        end
      end else begin
        stage[0] <= resolved;
        for (int k = 1; k < wr_latency; k++) begin
          stage[k] <= stage[k-1];
        end
      end
    end

    // Last stage feeds the storage
    assign mem_wr = stage[wr_latency-1];
  end

endmodule

// ==== src/flop_ram_pkg.sv ====
// Flop RAM package with the storage geometry and the request and response structs
package flop_ram_pkg;

  // Geometry of the storage array
  localparam int ram_depth = 16;
  localparam int addr_w    = 4;
  localparam int data_w    = 32;
  localparam int lane_w    = 8;
  localparam int num_lanes = data_w / lane_w;

  // Width of the monitor error counter
  localparam int cnt_w = 16;

  typedef struct packed {
    logic                 valid;
    logic [addr_w-1:0]    addr;
    logic [data_w-1:0]    data;
    logic [num_lanes-1:0] lane_en;
  } wr_req_t;

  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
  } rd_resp_t;

endpackage
